// ==== Makefile ====
# Verilator build and run of the map viewer testbench
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 -f list.f --top-module mapViewerTb -o simv
	./obj_dir/simv > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "Simulation PASSED" $(LOG); then echo "no verdict in $(LOG)"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/mapViewerTb.sv ====
/*
 * Map viewer testbench.
 * LFSR driven key sessions, frame ticks and pixel bursts, checked
 * against a reference model of the motion rules and the pixel path.
 */
`timescale 1ns/1ps

module mapViewerTb;
    import viewPkg::*;

    localparam int Period        = 40;
    localparam int ResetCycles   = 16;
    localparam int IdleTicks     = 20;
    localparam int NumSessions   = 32;
    localparam int MaxTicks      = 511;
    localparam int MaxStretch    = 7;
    localparam int PixPerSession = 48;
    // worst case cycles of one session, ticks take two cycles each
    localparam int SessionCycles = 2 * MaxTicks + PixPerSession + MaxStretch + 12;
    localparam int LimitCycles   = ResetCycles + 2 * IdleTicks
                                 + NumSessions * SessionCycles + 64;
    localparam logic [31:0] Seed = 32'd74057;

    // window edges as plain integers
    localparam int WinLeft   = int'(WinX0);
    localparam int WinRight  = int'(WinX0) + int'(WinW);
    localparam int WinTop    = int'(WinY0);
    localparam int WinBottom = int'(WinY0) + int'(WinH);

    // reference palette
    localparam rgb12T refPalette [16] = '{
        12'h000, 12'h2A3, 12'h3B4, 12'h4C5,
        12'h6D3, 12'h8C4, 12'hA95, 12'h864,
        12'h27C, 12'h39D, 12'hCC8, 12'hEDA,
        12'hFFF, 12'hF44, 12'hFC6, 12'h555
    };

    logic  Clock     = 1'b0;
    logic  Reset     = 1'b1;
    logic  keyReq    = 1'b0;
    keyT   keyCode   = '0;
    logic  frameTick = 1'b0;
    coordT drawX     = '0;
    coordT drawY     = '0;
    logic  videoOn   = 1'b0;
    logic  keyAck;
    chanT  red;
    chanT  green;
    chanT  blue;
    coordT camX;
    coordT camY;
    coordT sprX;
    coordT sprY;

    // model state
    logic [31:0] lfsr;
    keyT         mKey;
    int          mCamX;
    int          mCamY;
    int          mSprX;
    int          mSprY;
    nibT         refImage [64];

    mapViewer i_dut (.*);

    always #(Period / 2) Clock = ~Clock;

    // --------------------
    // random source, one LFSR step per bit
    function automatic int randBits(input int n);
        int v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    function automatic keyT pickKey();
        case (randBits(3))
            0, 4: return KeyA;
            1, 5: return KeyD;
            2: return KeyW;
            3: return KeyS;
            // any other code holds still
            6: return keyT'(randBits(8));
            default: return '0;
        endcase
    endfunction

    // --------------------
    // reference model
    function automatic int keyStep(input keyT k, input bit vertical);
        if (!vertical && k == KeyA) return -1;
        if (!vertical && k == KeyD) return 1;
        if (vertical && k == KeyW) return -1;
        if (vertical && k == KeyS) return 1;
        return 0;
    endfunction

    // scroll from the centre if the camera has room, else walk in the box
    task automatic axisStep(input int step, input int camMax, input int sprMin,
                            input int sprMax, input int sprCtr,
                            inout int cam, inout int spr);
        if (step != 0) begin
            if (spr == sprCtr && cam + step >= 0 && cam + step <= camMax) begin
                cam = cam + step;
            end else if (spr + step >= sprMin && spr + step <= sprMax) begin
                spr = spr + step;
            end
        end
    endtask

    function automatic rgb12T expectColour(input int x, input int y, input bit on);
        int mapX;
        int mapY;
        int idx;
        int dx;
        int dy;
        nibT sIdx;
        if (!on || x < WinLeft || x >= WinRight || y < WinTop || y >= WinBottom) begin
            return 12'h000;
        end
        mapX = (x - WinLeft) / 2 + mCamX;
        mapY = (y - WinTop) / 2 + mCamY;
        idx  = ((mapX / 16) + (mapY / 16)) % 16;
        dx   = x - (mSprX - 8);
        dy   = y - (mSprY - 8);
        // sprite square, 2x2 screen pixels per image pixel
        if (dx >= 0 && dx < 16 && dy >= 0 && dy < 16) begin
            sIdx = refImage[6'((dy / 2) * 8 + dx / 2)];
            if (sIdx != 4'd0) idx = int'(sIdx);
        end
        return refPalette[4'(idx)];
    endfunction

    // --------------------
    // compare tasks
    task automatic checkCoord(input coordT got, input coordT want, input string what);
        if (got !== want) begin
            $display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
            $display("Simulation FAILED");
            $fatal(1, "position mismatch");
        end
    endtask

    task automatic checkChan(input chanT got, input chanT want, input string what);
        if (got !== want) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, want);
            $display("Simulation FAILED");
            $fatal(1, "colour mismatch");
        end
    endtask

    task automatic checkAck(input logic got, input logic want, input string what);
        if (got !== want) begin
            $display("Fail at %0t ns: keyAck %s is %b, expected %b", $time, what, got, want);
            $display("Simulation FAILED");
            $fatal(1, "handshake mismatch");
        end
    endtask

    task automatic checkPositions();
        checkCoord(camX, coordT'(mCamX), "camX");
        checkCoord(camY, coordT'(mCamY), "camY");
        checkCoord(sprX, coordT'(mSprX), "sprX");
        checkCoord(sprY, coordT'(mSprY), "sprY");
    endtask

    // --------------------
    // stimulus
    task automatic keySession(input keyT code);
        int stretch;
        @(posedge Clock);
        keyReq  <= 1'b1;
        keyCode <= code;
        @(negedge Clock);
        checkAck(keyAck, 1'b0, "before req sampled");
        @(posedge Clock);
        @(negedge Clock);
        checkAck(keyAck, 1'b1, "after req sampled");
        mKey = code;
        // slow controller holds req a while
        stretch = randBits(3);
        repeat (stretch) begin
            @(negedge Clock);
            checkAck(keyAck, 1'b1, "while req held");
        end
        @(posedge Clock);
        keyReq  <= 1'b0;
        // bus content no longer valid
        keyCode <= keyT'(randBits(8));
        @(negedge Clock);
        checkAck(keyAck, 1'b1, "before release sampled");
        @(posedge Clock);
        @(negedge Clock);
        checkAck(keyAck, 1'b0, "after release sampled");
    endtask

    task automatic tickBurst(input int count);
        repeat (count) begin
            @(posedge Clock);
            frameTick <= 1'b1;
            @(posedge Clock);
            frameTick <= 1'b0;
            axisStep(keyStep(mKey, 1'b0), int'(CamXMax), int'(SprXMin),
                     int'(SprXMax), int'(SprXCtr), mCamX, mSprX);
            axisStep(keyStep(mKey, 1'b1), int'(CamYMax), int'(SprYMin),
                     int'(SprYMax), int'(SprYCtr), mCamY, mSprY);
            @(negedge Clock);
            checkPositions();
        end
    endtask

    task automatic pickPixel(output int x, output int y, output bit on);
        int mode;
        mode = randBits(2);
        on = 1'b1;
        case (mode)
            0: begin
                x = WinLeft + randBits(9) % int'(WinW);
                y = WinTop + randBits(9) % int'(WinH);
            end
            // inside the sprite square
            1: begin
                x = mSprX - 8 + randBits(4);
                y = mSprY - 8 + randBits(4);
            end
            // whole screen, blanking at random
            2: begin
                x  = randBits(10) % 640;
                y  = randBits(9) % 480;
                on = randBits(1) != 0;
            end
            default: begin
                x  = WinLeft + randBits(9) % int'(WinW);
                y  = WinTop + randBits(9) % int'(WinH);
                on = 1'b0;
            end
        endcase
    endtask

    // new pixel every cycle, the previous one checked meanwhile
    task automatic pixelBurst(input int count);
        int    x;
        int    y;
        bit    on;
        rgb12T want;
        rgb12T pend;
        bit    havePend;
        want     = '0;
        pend     = '0;
        havePend = 1'b0;
        for (int i = 0; i <= count; i++) begin
            @(posedge Clock);
            if (i < count) begin
                pickPixel(x, y, on);
                drawX   <= coordT'(x);
                drawY   <= coordT'(y);
                videoOn <= on;
                want = expectColour(x, y, on);
            end
            @(negedge Clock);
            if (havePend) begin
                checkChan(red, {pend[11:8], 4'h0}, "red");
                checkChan(green, {pend[7:4], 4'h0}, "green");
                checkChan(blue, {pend[3:0], 4'h0}, "blue");
            end
            pend     = want;
            havePend = (i < count);
        end
    endtask

    // --------------------
    // main sequence
    initial begin
        lfsr  = Seed;
        mKey  = '0;
        mCamX = 0;
        mCamY = 0;
        mSprX = int'(SprXCtr);
        mSprY = int'(SprYCtr);
        $readmemh("hw/sprite.hex", refImage);

        repeat (ResetCycles) @(posedge Clock);
        Reset <= 1'b0;
        @(negedge Clock);
        checkAck(keyAck, 1'b0, "after reset");
        checkPositions();
        // registers still hold their reset value here
        checkChan(red, 8'h00, "red at reset release");
        checkChan(green, 8'h00, "green at reset release");
        checkChan(blue, 8'h00, "blue at reset release");
        @(posedge Clock);
        @(negedge Clock);
        checkChan(red, 8'h00, "red after reset");
        checkChan(green, 8'h00, "green after reset");
        checkChan(blue, 8'h00, "blue after reset");

        // no key held yet, nothing may move
        tickBurst(IdleTicks);
        checkCoord(camX, '0, "idle camX");
        checkCoord(camY, '0, "idle camY");
        checkCoord(sprX, SprXCtr, "idle sprX");
        checkCoord(sprY, SprYCtr, "idle sprY");

        for (int s = 0; s < NumSessions; s++) begin
            keySession(pickKey());
            tickBurst(randBits(9));
            pixelBurst(PixPerSession);
        end

        if (i_dut.i_chk.assertFails == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("Checker assertions failed %0d times", i_dut.i_chk.assertFails);
            $display("Simulation FAILED");
            $fatal(1, "assertion failures");
        end
    end

    // --------------------
    // watchdog
    initial begin
        #(LimitCycles * Period);
        $display("Watchdog expired, the run took longer than all tests should");
        $display("Simulation FAILED");
        $fatal(1, "timeout");
    end

endmodule

// ==== bench/mapViewer_chk.sv ====
/*
 * Map viewer checker.
 * Concurrent assertions on the key handshake and the position bounds,
 * bound into the top level.
 */
`timescale 1ns/1ps

module mapViewer_chk (
    input logic           Clock,
    input logic           Reset,
    input logic           keyReq,
    input logic           keyAck,
    input viewPkg::coordT camX,
    input viewPkg::coordT camY,
    input viewPkg::coordT sprX,
    input viewPkg::coordT sprY
);
    import viewPkg::*;

    // read by the testbench at the end of the run
    int assertFails = 0;

    // --------------------
    // ack answers a request seen one cycle earlier
    ackRise: assert property (@(posedge Clock) disable iff (Reset)
        $rose(keyAck) |-> $past(keyReq))
        else begin
            assertFails++;
            $error("keyAck rose while keyReq was low");
        end

    // ack drops only once the request is gone
    ackFall: assert property (@(posedge Clock) disable iff (Reset)
        $fell(keyAck) |-> !$past(keyReq))
        else begin
            assertFails++;
            $error("keyAck fell while keyReq was high");
        end

    // --------------------
    // camera and sprite inside their limits
    boundsX: assert property (@(posedge Clock) disable iff (Reset)
        (camX <= CamXMax) && (sprX >= SprXMin) && (sprX <= SprXMax))
        else begin
            assertFails++;
            $error("x position out of bounds, camX %0d sprX %0d", camX, sprX);
        end

    boundsY: assert property (@(posedge Clock) disable iff (Reset)
        (camY <= CamYMax) && (sprY >= SprYMin) && (sprY <= SprYMax))
        else begin
            assertFails++;
            $error("y position out of bounds, camY %0d sprY %0d", camY, sprY);
        end

endmodule

bind mapViewer mapViewer_chk i_chk (
    .Clock  (Clock),
    .Reset  (Reset),
    .keyReq (keyReq),
    .keyAck (keyAck),
    .camX   (camX),
    .camY   (camY),
    .sprX   (sprX),
    .sprY   (sprY)
);

// ==== hw/axisMotion.sv ====
/*
 * Axis motion.
 * Camera and sprite position for one axis, one move per frame tick.
 * The camera scrolls only while the sprite sits on the centre,
 * otherwise the sprite walks inside its box.
 */
`timescale 1ns/1ps

module axisMotion #(
    parameter viewPkg::coordT CamMax = viewPkg::CamXMax,
    parameter viewPkg::coordT SprMin = viewPkg::SprXMin,
    parameter viewPkg::coordT SprMax = viewPkg::SprXMax,
    parameter viewPkg::coordT SprCtr = viewPkg::SprXCtr
) (
    input  logic           Clock,
    input  logic           Reset,
    input  logic           frameTick,
    input  viewPkg::stepT  step,
    output viewPkg::coordT cam,
    output viewPkg::coordT spr
);
    import viewPkg::*;

    localparam int W = $bits(coordT);

    // one extra bit, a step below zero wraps high and fails the upper bound
    logic [W:0] stepWide;
    logic [W:0] camTry;
    logic [W:0] sprTry;
    logic       moving;
    logic       camMove;
    logic       sprMove;

    // --------------------
    // candidate positions
    assign stepWide = {{(W - 1){step[1]}}, step};
    assign camTry   = {1'b0, cam} + stepWide;
    assign sprTry   = {1'b0, spr} + stepWide;
    assign moving   = (step != stepT'(0));

    // scroll from the exact centre only, camera within 0..CamMax
    assign camMove = moving && (spr == SprCtr) && (camTry <= {1'b0, CamMax});

    // otherwise walk, clamped to the box
    assign sprMove = moving && (sprTry >= {1'b0, SprMin})
                            && (sprTry <= {1'b0, SprMax});

    // --------------------
    // position registers
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            cam <= '0;
            spr <= SprCtr;
        end else if (frameTick) begin
            if (camMove) begin
                cam <= camTry[W-1:0];
            end else if (sprMove) begin
                spr <= sprTry[W-1:0];
            end
        end
    end

endmodule

// ==== hw/keyLatch.sv ====
/*
 * Key receiver.
 * Four-phase req/ack slave towards the keyboard controller. Holds
 * the last key handed over and decodes it into one step per axis.
 */
`timescale 1ns/1ps

module keyLatch (
    input  logic          Clock,
    input  logic          Reset,
    input  logic          keyReq,
    input  viewPkg::keyT  keyCode,
    output logic          keyAck,
    output viewPkg::stepT stepX,
    output viewPkg::stepT stepY
);
    import viewPkg::*;

    typedef enum logic {Idle, Acked} stateT;

    stateT state;
    // key stays held until the next exchange
    keyT   heldKey;

    // --------------------
    // handshake FSM
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            state   <= Idle;
            // no key held
            heldKey <= '0;
        end else begin
            case (state)
                Idle: begin
                    // capture on the way into Acked
                    if (keyReq) begin
                        state   <= Acked;
                        heldKey <= keyCode;
                    end
                end
                Acked: begin
                    // wait for the controller to drop req
                    if (!keyReq) begin
                        state <= Idle;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    assign keyAck = (state == Acked);

    // --------------------
    // single key decode, anything else stands still
    always_comb begin
        stepX = stepT'(0);
        stepY = stepT'(0);
        case (heldKey)
            KeyA: stepX = stepT'(-1);
            KeyD: stepX = stepT'(1);
            KeyW: stepY = stepT'(-1);
            KeyS: stepY = stepT'(1);
            default: ;
        endcase
    end

endmodule

// ==== hw/mapViewer.sv ====
/*
 * Map viewer top level.
 * Key receiver, x and y motion units and the pixel path
 * for a scrolling 480x320 map on a 640x480 display.
 */
`timescale 1ns/1ps

module mapViewer (
    input  logic           Clock,
    input  logic           Reset,
    input  logic           keyReq,
    input  viewPkg::keyT   keyCode,
    output logic           keyAck,
    input  logic           frameTick,
    input  viewPkg::coordT drawX,
    input  viewPkg::coordT drawY,
    input  logic           videoOn,
    output viewPkg::chanT  red,
    output viewPkg::chanT  green,
    output viewPkg::chanT  blue,
    output viewPkg::coordT camX,
    output viewPkg::coordT camY,
    output viewPkg::coordT sprX,
    output viewPkg::coordT sprY
);
    import viewPkg::*;

    stepT stepX;
    stepT stepY;
    logic sprHit;
    nibT  sprIndex;

    // --------------------
    // key handover and decode
    keyLatch i_keyLatch (
        .Clock   (Clock),
        .Reset   (Reset),
        .keyReq  (keyReq),
        .keyCode (keyCode),
        .keyAck  (keyAck),
        .stepX   (stepX),
        .stepY   (stepY)
    );

    // horizontal camera and sprite
    axisMotion #(
        .CamMax (CamXMax),
        .SprMin (SprXMin),
        .SprMax (SprXMax),
        .SprCtr (SprXCtr)
    ) i_axisX (
        .Clock     (Clock),
        .Reset     (Reset),
        .frameTick (frameTick),
        .step      (stepX),
        .cam       (camX),
        .spr       (sprX)
    );

    // vertical camera and sprite
    axisMotion #(
        .CamMax (CamYMax),
        .SprMin (SprYMin),
        .SprMax (SprYMax),
        .SprCtr (SprYCtr)
    ) i_axisY (
        .Clock     (Clock),
        .Reset     (Reset),
        .frameTick (frameTick),
        .step      (stepY),
        .cam       (camY),
        .spr       (sprY)
    );

    // --------------------
    // pixel path
    spriteUnit i_spriteUnit (
        .drawX    (drawX),
        .drawY    (drawY),
        .sprX     (sprX),
        .sprY     (sprY),
        .sprHit   (sprHit),
        .sprIndex (sprIndex)
    );

    pixelComposer i_pixelComposer (
        .Clock    (Clock),
        .Reset    (Reset),
        .drawX    (drawX),
        .drawY    (drawY),
        .camX     (camX),
        .camY     (camY),
        .videoOn  (videoOn),
        .sprHit   (sprHit),
        .sprIndex (sprIndex),
        .red      (red),
        .green    (green),
        .blue     (blue)
    );

endmodule

// ==== hw/pixelComposer.sv ====
/*
 * Pixel composer.
 * Window test, tiled background index, sprite overlay, palette
 * lookup and the registered 8-bit RGB output.
 */
`timescale 1ns/1ps

module pixelComposer (
    input  logic           Clock,
    input  logic           Reset,
    input  viewPkg::coordT drawX,
    input  viewPkg::coordT drawY,
    input  viewPkg::coordT camX,
    input  viewPkg::coordT camY,
    input  logic           videoOn,
    input  logic           sprHit,
    input  viewPkg::nibT   sprIndex,
    output viewPkg::chanT  red,
    output viewPkg::chanT  green,
    output viewPkg::chanT  blue
);
    import viewPkg::*;

    logic  inWin;
    coordT relX;
    coordT relY;
    coordT mapX;
    coordT mapY;
    coordT tileSum;
    nibT   bgIndex;
    nibT   pixIndex;
    rgb12T colour;

    // --------------------
    // 480x320 window at 80,80
    assign inWin = (drawX >= WinX0) && (drawX < WinX0 + WinW)
                && (drawY >= WinY0) && (drawY < WinY0 + WinH);

    // window relative, halved for 2x scale, then shifted by the camera
    assign relX = drawX - WinX0;
    assign relY = drawY - WinY0;
    assign mapX = (relX >> 1) + camX;
    assign mapY = (relY >> 1) + camY;

    // checker-like diagonal bands, tile col plus tile row
    assign tileSum = (mapX >> TileShift) + (mapY >> TileShift);
    assign bgIndex = tileSum[3:0];

    // --------------------
    // overlay and palette
    assign pixIndex = sprHit ? sprIndex : bgIndex;
    assign colour   = palette[pixIndex];

    // one pixel in flight, black outside the window or in blanking
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else if (videoOn && inWin) begin
            // nibble widened with four zero bits
            red   <= {colour[11:8], 4'b0000};
            green <= {colour[7:4], 4'b0000};
            blue  <= {colour[3:0], 4'b0000};
        end else begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end
    end

endmodule

// ==== hw/sprite.hex ====
// 8x8 sprite image, one image row per line, top row first
// columns are eight palette indices left to right, 0 shows the map
0 0 d d d d 0 0
0 d e e e e d 0
d e c 8 8 c e d
d e c 8 8 c e d
d e e e e e e d
0 d e 7 7 e d 0
0 0 d 7 7 d 0 0
0 0 7 0 0 7 0 0

// ==== hw/spriteUnit.sv ====
/*
 * Sprite unit.
 * Hit test of the current pixel against the 16x16 sprite square,
 * image lookup at half resolution and the transparency flag.
 */
`timescale 1ns/1ps

module spriteUnit (
    input  viewPkg::coordT drawX,
    input  viewPkg::coordT drawY,
    input  viewPkg::coordT sprX,
    input  viewPkg::coordT sprY,
    output logic           sprHit,
    output viewPkg::nibT   sprIndex
);
    import viewPkg::*;

    // bits of one image row or column address
    localparam int IdxW = $clog2(SprSize);

    // 8x8 image, row major
    nibT   image [SprSize * SprSize];

    coordT offX;
    coordT offY;
    logic  inBox;

    initial begin
        $readmemh("hw/sprite.hex", image);
    end

    // --------------------
    // offsets from the square's top left corner
    // left of the square wraps to a large value
    assign offX = drawX - sprX + coordT'(SprSize);
    assign offY = drawY - sprY + coordT'(SprSize);

    // square is sprX-8 .. sprX+7 by sprY-8 .. sprY+7
    assign inBox = (offX < coordT'(2 * SprSize)) && (offY < coordT'(2 * SprSize));

    // --------------------
    // image read, offset halved for the 2x draw
    assign sprIndex = image[{offY[IdxW:1], offX[IdxW:1]}];

    // transparent pixels let the background through
    assign sprHit = inBox && (sprIndex != Transparent);

endmodule

// ==== hw/viewPkg.sv ====
/*
 * Map viewer shared definitions.
 * Widths with a meaning, keyboard usage codes, screen window and
 * map geometry, sprite box limits and the background palette.
 */
package viewPkg;

    // --------------------
    // vector types
    // screen, map or camera coordinate
    typedef logic [9:0] coordT;
    // keyboard usage code
    typedef logic [7:0] keyT;
    // -1, 0 or +1 along one axis
    typedef logic signed [1:0] stepT;
    // colour nibble or palette index
    typedef logic [3:0] nibT;
    // output colour channel
    typedef logic [7:0] chanT;
    // packed palette entry, red in the top nibble
    typedef logic [11:0] rgb12T;

    // --------------------
    // usage codes for the four movement keys
    localparam keyT KeyA = 8'h04;
    localparam keyT KeyD = 8'h07;
    localparam keyT KeyW = 8'h1A;
    localparam keyT KeyS = 8'h16;

    // game window on the 640x480 screen
    localparam coordT WinX0 = 10'd80;
    localparam coordT WinY0 = 10'd80;
    localparam coordT WinW  = 10'd480;
    localparam coordT WinH  = 10'd320;

    // camera limits over the 480x320 map
    localparam coordT CamXMax = 10'd240;
    localparam coordT CamYMax = 10'd160;

    // sprite box and centre, screen coordinates
    localparam coordT SprXMin = 10'd100;
    localparam coordT SprXMax = 10'd539;
    localparam coordT SprXCtr = 10'd320;
    localparam coordT SprYMin = 10'd100;
    localparam coordT SprYMax = 10'd379;
    localparam coordT SprYCtr = 10'd240;

    // sprite image side, each pixel drawn 2x2
    localparam int SprSize = 8;
    // 16 map pixels per tile
    localparam int TileShift = 4;
    // sprite index that lets the map show through
    localparam nibT Transparent = 4'd0;

    // --------------------
    // shared by the map tiles and the sprite
    localparam rgb12T palette [16] = '{
        12'h000, 12'h2A3, 12'h3B4, 12'h4C5,
        12'h6D3, 12'h8C4, 12'hA95, 12'h864,
        12'h27C, 12'h39D, 12'hCC8, 12'hEDA,
        12'hFFF, 12'hF44, 12'hFC6, 12'h555
    };

endpackage

// ==== list.f ====
hw/viewPkg.sv
hw/keyLatch.sv
hw/axisMotion.sv
hw/spriteUnit.sv
hw/pixelComposer.sv
hw/mapViewer.sv
bench/mapViewer_chk.sv
bench/mapViewerTb.sv
